/* files.f */
pred_pkg.sv
pred_ifs.sv
pred_btb.sv
pred_bim.sv
pred_ras.sv
pred_select.sv
pred_top.sv
tb_pred_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pred_top
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* tb_pred_top.sv */
// testbench for the fetch-stage branch predictor
// clock, reset, lfsr, reference model, stimulus tasks and checks

`timescale 1ns/1ns

module tb_pred_top;
  import pred_pkg::*;

  localparam int MAX_CYCLES = 400;
  // rvc / rv32 parcels used to build fetch blocks
  localparam logic [15:0] C_NOP    = 16'h0001;
  localparam logic [15:0] C_JAL    = 16'h2001;
  localparam logic [15:0] C_RET    = 16'h8082;
  // low halves of jal ra,0 and jalr x0,x1,0
  localparam logic [15:0] JAL_RA   = 16'h00ef;
  localparam logic [15:0] JALR_RET = 16'h8067;

  logic                 i_clk, i_reset_n;
  logic                 i_s0_valid, i_s2_valid;
  logic [VADDR_W-1:0]   i_s0_vaddr;
  logic [63:0]          i_s2_data;
  logic [7:0]           i_s2_be;
  logic                 i_upd_valid, i_upd_taken, i_upd_is_call, i_upd_is_ret, i_upd_dead;
  logic [VADDR_W-1:0]   i_upd_pc, i_upd_target;
  logic [RAS_IDX_W-1:0] i_upd_ras_index;
  logic                 o_s2_taken, o_s2_is_call, o_s2_is_ret;
  logic [VADDR_W-1:0]   o_s2_target;
  logic [RAS_IDX_W-1:0] o_s2_ras_index;

  int          errors, test_err, n_pass, n_fail, cycles;
  logic [15:0] lfsr;

  // reference model state
  logic        m_valid  [BTB_ENTRIES][FETCH_SLOTS];
  logic [7:0]  m_tag    [BTB_ENTRIES][FETCH_SLOTS];
  logic [31:0] m_target [BTB_ENTRIES][FETCH_SLOTS];
  // 0 strong nt .. 3 strong t
  int          m_cnt    [BTB_ENTRIES][FETCH_SLOTS];
  logic [31:0] m_stack  [RAS_ENTRIES];
  logic [2:0]  m_ptr;
  logic        m_recover;

  pred_top dut (.*);

  always #50 i_clk = ~i_clk;

  // run limit
  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // nothing is predicted while s2 is idle
  idle_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_s2_valid |-> !(o_s2_taken || o_s2_is_call || o_s2_is_ret))
  else begin
    $display("prediction outputs active while s2 is idle");
    errors++;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int b = 0; b < 32; b++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic expect_val(input string name, input logic [31:0] act, input logic [31:0] exp);
    assert (act === exp) else begin
      $display("Fail %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic end_test(input string name);
    if (errors == test_err) begin
      $display("test %s: ok", name);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", name, errors - test_err);
      n_fail++;
    end
    test_err = errors;
  endtask

  // expected s2 result and the model ras step
  task automatic model_fetch(input logic [31:0] va, input logic [63:0] data,
                             input logic [7:0] be, output logic e_taken, output logic e_call,
                             output logic e_ret, output logic [31:0] e_tgt,
                             output logic [2:0] e_idx);
    logic [3:0]  vld, rcall, scall, ret, call;
    logic [15:0] p;
    logic [31:0] w;
    logic        sret, hit;
    int          idx, sel;
    idx = va[6:3];
    for (int i = 0; i < 4; i++) begin
      p = data[i*16 +: 16];
      vld[i] = be[2*i];
      rcall[i] = (p[1:0] == 2'b01 && p[15:13] == 3'b001) ||
                 (p[1:0] == 2'b10 && p[15:12] == 4'b1001 && p[11:7] != 0 && p[6:2] == 0);
      scall[i] = 1'b0;
      sret = 1'b0;
      // a 32-bit op in the last parcel runs past the block
      if (i < 3) begin
        w = data[i*16 +: 32];
        scall[i] = w[11:7] == 5'd1 &&
                   (w[6:0] == 7'h6f || (w[6:0] == 7'h67 && w[14:12] == 3'd0));
        sret = w == 32'h0000_8067;
      end
      ret[i] = (p == C_RET || sret) && vld[i];
    end
    sel = -1;
    for (int i = 3; i >= 0; i--) begin
      call[i] = (rcall[i] || scall[i] || (i > 0 && scall[i-1])) && vld[i];
      hit = m_valid[idx][i] && m_tag[idx][i] == va[14:7] && m_cnt[idx][i] >= 2;
      if ((hit || call[i] || ret[i]) && vld[i]) begin
        sel = i;
      end
    end
    e_taken = sel >= 0;
    e_call  = sel >= 0 && call[sel];
    e_ret   = sel >= 0 && ret[sel] && !call[sel];
    e_idx   = m_ptr;
    e_tgt   = '0;
    if (e_ret) begin
      e_tgt = m_stack[m_ptr];
      m_ptr = m_ptr - 3'd1;
    end else if (e_call) begin
      m_ptr = m_ptr + 3'd1;
      m_stack[m_ptr] = {va[31:3], 3'b000} + 32'(sel * 2) + (scall[sel] ? 32'd4 : 32'd2);
    end else if (e_taken) begin
      e_tgt = m_target[idx][sel];
    end
  endtask

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic send_update(input logic [31:0] pc, input logic [31:0] tgt, input logic taken,
                             input logic call, input logic ret, input logic dead,
                             input logic [2:0] ridx);
    int idx, sl;
    idx = pc[6:3];
    sl  = pc[2:1];
    @(negedge i_clk);
    {i_upd_valid, i_upd_pc, i_upd_target, i_upd_taken} = {1'b1, pc, tgt, taken};
    {i_upd_is_call, i_upd_is_ret, i_upd_dead, i_upd_ras_index} = {call, ret, dead, ridx};
    if (taken && !ret) begin
      m_valid[idx][sl]  = 1'b1;
      m_tag[idx][sl]    = pc[14:7];
      m_target[idx][sl] = tgt;
    end
    if (taken && m_cnt[idx][sl] < 3) begin
      m_cnt[idx][sl]++;
    end else if (!taken && m_cnt[idx][sl] > 0) begin
      m_cnt[idx][sl]--;
    end
    // first dead call or return restores the pointer and a good one ends recovery
    if ((call || ret) && dead && !m_recover) begin
      m_ptr = ridx;
    end
    if (call || ret) begin
      m_recover = dead;
    end
    @(negedge i_clk);
    i_upd_valid = 1'b0;
  endtask

  // s0 address and the s2 parcels two cycles later
  task automatic fetch_block(input logic [31:0] va, input logic [63:0] data, input logic [7:0] be);
    logic        e_taken, e_call, e_ret;
    logic [31:0] e_tgt;
    logic [2:0]  e_idx;
    @(negedge i_clk);
    i_s0_valid = 1'b1;
    i_s0_vaddr = va;
    @(negedge i_clk);
    i_s0_valid = 1'b0;
    @(negedge i_clk);
    i_s2_valid = 1'b1;
    i_s2_data  = data;
    i_s2_be    = be;
    model_fetch(va, data, be, e_taken, e_call, e_ret, e_tgt, e_idx);
    #25;
    expect_val("o_s2_taken", o_s2_taken, e_taken);
    expect_val("o_s2_is_call", o_s2_is_call, e_call);
    expect_val("o_s2_is_ret", o_s2_is_ret, e_ret);
    expect_val("o_s2_ras_index", o_s2_ras_index, e_idx);
    // call target comes from whatever the btb holds
    if (!e_call) begin
      expect_val("o_s2_target", o_s2_target, e_tgt);
    end
    @(negedge i_clk);
    i_s2_valid = 1'b0;
  endtask

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    logic [31:0] base, tgt, va;
    {i_clk, i_reset_n, i_s0_valid, i_s0_vaddr, i_s2_valid, i_s2_data, i_s2_be} = '0;
    {i_upd_valid, i_upd_pc, i_upd_target, i_upd_taken} = '0;
    {i_upd_is_call, i_upd_is_ret, i_upd_dead, i_upd_ras_index} = '0;
    {errors, test_err, n_pass, n_fail, cycles} = '0;
    lfsr = 16'd36;
    m_ptr = '0;
    m_recover = 1'b0;
    for (int e = 0; e < BTB_ENTRIES; e++) begin
      for (int s = 0; s < FETCH_SLOTS; s++) begin
        m_valid[e][s] = 1'b0;
        m_cnt[e][s]   = 1;
      end
    end
    repeat (3) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    #25;
    expect_val("o_s2_taken", o_s2_taken, 0);
    expect_val("o_s2_is_call", o_s2_is_call, 0);
    expect_val("o_s2_is_ret", o_s2_is_ret, 0);
    expect_val("o_s2_ras_index", o_s2_ras_index, 0);
    fetch_block(32'h0000_1000, {4{C_NOP}}, 8'hff);
    // c.jr ra in a parcel that is not enabled
    fetch_block(32'h0000_1008, {C_NOP, C_RET, C_NOP, C_NOP}, 8'hcf);
    end_test("reset state");

    rand_word(base);
    base[2:0] = 3'b000;
    rand_word(tgt);
    tgt[0] = 1'b0;
    send_update(base + 32'd2, tgt, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
    send_update(base + 32'd2, tgt, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
    fetch_block(base, {4{C_NOP}}, 8'hff);
    send_update(base + 32'd2, tgt, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0);
    fetch_block(base, {4{C_NOP}}, 8'hff);
    fetch_block(base ^ 32'h80, {4{C_NOP}}, 8'hff);
    end_test("btb and bimodal training");

    // standard call in slot 1, compressed call in slot 0, two returns
    rand_word(base);
    base[2:0] = 3'b000;
    fetch_block(base, {C_NOP, 16'h0000, JAL_RA, C_NOP}, 8'hff);
    rand_word(va);
    va[2:0] = 3'b000;
    fetch_block(va, {C_NOP, C_NOP, C_NOP, C_JAL}, 8'hff);
    rand_word(va);
    va[2:0] = 3'b000;
    fetch_block(va, {C_NOP, C_NOP, C_NOP, C_RET}, 8'hff);
    fetch_block(va, {C_NOP, C_NOP, 16'h0000, JALR_RET}, 8'hff);
    end_test("call push and return pop");

    rand_word(base);
    base[2:0] = 3'b000;
    rand_word(tgt);
    tgt[0] = 1'b0;
    send_update(base + 32'd4, tgt, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
    send_update(base + 32'd4, tgt, 1'b1, 1'b0, 1'b0, 1'b0, 3'd0);
    // a push first so the return pops a known address
    rand_word(va);
    va[2:0] = 3'b000;
    fetch_block(va, {C_NOP, C_NOP, C_NOP, C_JAL}, 8'hff);
    fetch_block(base, {C_NOP, C_NOP, C_NOP, C_RET}, 8'hff);
    fetch_block(base, {C_RET, C_NOP, C_NOP, C_NOP}, 8'hff);
    rand_word(va);
    va[2:0] = 3'b000;
    fetch_block(va, {JAL_RA, C_NOP, C_NOP, C_NOP}, 8'hff);
    end_test("priority");

    repeat (3) begin
      rand_word(va);
      va[2:0] = 3'b000;
      fetch_block(va, {C_NOP, C_NOP, C_NOP, C_JAL}, 8'hff);
    end
    send_update(va, 32'd0, 1'b0, 1'b1, 1'b0, 1'b1, 3'd1);
    rand_word(base);
    base[2:0] = 3'b000;
    fetch_block(base, {4{C_NOP}}, 8'hff);
    // still recovering so this one is ignored
    send_update(va, 32'd0, 1'b0, 1'b1, 1'b0, 1'b1, 3'd5);
    fetch_block(base, {4{C_NOP}}, 8'hff);
    end_test("recovery");

    $display("tests passed: %0d, tests failed: %0d", n_pass, n_fail);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* pred_top.sv */
// predictor top level with plain ports
// btb, bimodal table, ras and s2 selection

`timescale 1ns/1ns

module pred_top (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  // fetch lookup
  input  logic                              i_s0_valid,
  input  logic [pred_pkg::VADDR_W-1:0]       i_s0_vaddr,
  input  logic                              i_s2_valid,
  input  logic [pred_pkg::FETCH_SLOTS*16-1:0] i_s2_data,
  input  logic [pred_pkg::FETCH_SLOTS*2-1:0]  i_s2_be,
  // branch resolution
  input  logic                              i_upd_valid,
  input  logic [pred_pkg::VADDR_W-1:0]       i_upd_pc,
  input  logic [pred_pkg::VADDR_W-1:0]       i_upd_target,
  input  logic                              i_upd_taken,
  input  logic                              i_upd_is_call,
  input  logic                              i_upd_is_ret,
  input  logic                              i_upd_dead,
  input  logic [pred_pkg::RAS_IDX_W-1:0]     i_upd_ras_index,
  // prediction
  output logic                              o_s2_taken,
  output logic [pred_pkg::VADDR_W-1:0]       o_s2_target,
  output logic                              o_s2_is_call,
  output logic                              o_s2_is_ret,
  output logic [pred_pkg::RAS_IDX_W-1:0]     o_s2_ras_index
);
  import pred_pkg::*;

  br_upd_t            w_upd;
  logic [VADDR_W-1:0] r_s1_vaddr;
  logic [VADDR_W-1:0] r_s2_vaddr;

  btb_search_if search_btb_if ();
  bim_search_if search_bim_if ();
  ras_search_if ras_if ();

  // pack the update fields
  assign w_upd.valid     = i_upd_valid;
  assign w_upd.pc        = i_upd_pc;
  assign w_upd.target    = i_upd_target;
  assign w_upd.taken     = i_upd_taken;
  assign w_upd.is_call   = i_upd_is_call;
  assign w_upd.is_ret    = i_upd_is_ret;
  assign w_upd.dead      = i_upd_dead;
  assign w_upd.ras_index = i_upd_ras_index;

  // s0 address follows the block to s2
  always_ff @(posedge i_clk) begin
    r_s1_vaddr <= i_s0_vaddr;
    r_s2_vaddr <= r_s1_vaddr;
  end

  pred_btb u_btb (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_s0_valid    (i_s0_valid),
    .i_s0_vaddr    (i_s0_vaddr),
    .i_upd         (w_upd),
    .search_btb_if (search_btb_if)
  );

  pred_bim u_bim (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_s0_valid    (i_s0_valid),
    .i_s0_vaddr    (i_s0_vaddr),
    .i_upd         (w_upd),
    .search_bim_if (search_bim_if)
  );

  pred_ras u_ras (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .ras_search_if (ras_if)
  );

  pred_select u_select (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_s2_valid     (i_s2_valid),
    .i_s2_data      (i_s2_data),
    .i_s2_be        (i_s2_be),
    .i_s2_vaddr     (r_s2_vaddr),
    .i_upd          (w_upd),
    .search_btb_if  (search_btb_if),
    .search_bim_if  (search_bim_if),
    .ras_search_if  (ras_if),
    .o_s2_taken     (o_s2_taken),
    .o_s2_target    (o_s2_target),
    .o_s2_is_call   (o_s2_is_call),
    .o_s2_is_ret    (o_s2_is_ret),
    .o_s2_ras_index (o_s2_ras_index)
  );

endmodule

/* pred_select.sv */
// stage s2 call / return decode and target selection
// ras pointer and recovery after mispredicted calls and returns

`timescale 1ns/1ns

module pred_select (
  input  logic                              i_clk,
  input  logic                              i_reset_n,
  input  logic                              i_s2_valid,
  input  logic [pred_pkg::FETCH_SLOTS*16-1:0] i_s2_data,
  input  logic [pred_pkg::FETCH_SLOTS*2-1:0]  i_s2_be,
  input  logic [pred_pkg::VADDR_W-1:0]       i_s2_vaddr,
  input  pred_pkg::br_upd_t                 i_upd,
  btb_search_if.lookup                      search_btb_if,
  bim_search_if.lookup                      search_bim_if,
  ras_search_if.lookup                      ras_search_if,
  output logic                              o_s2_taken,
  output logic [pred_pkg::VADDR_W-1:0]       o_s2_target,
  output logic                              o_s2_is_call,
  output logic                              o_s2_is_ret,
  output logic [pred_pkg::RAS_IDX_W-1:0]     o_s2_ras_index
);
  import pred_pkg::*;

  logic [FETCH_SLOTS-1:0] w_slot_vld;
  logic [FETCH_SLOTS-1:0] w_rvc_call;
  logic [FETCH_SLOTS-1:0] w_std_call;
  logic [FETCH_SLOTS-1:0] w_std_ret;
  logic [FETCH_SLOTS-1:0] w_ret;
  logic [FETCH_SLOTS-1:0] w_call;
  logic [FETCH_SLOTS-1:0] w_cand;
  call_size_t             w_call_size [FETCH_SLOTS];

  logic [SLOT_W-1:0]    w_sel;
  logic                 w_sel_hit;
  logic                 w_win_call;
  logic                 w_win_ret;
  logic [VADDR_W-1:0]   w_ret_addr;

  logic                 r_recover;
  logic [RAS_IDX_W-1:0] r_ras_index;
  logic [RAS_IDX_W-1:0] w_cmt_index;
  logic [RAS_IDX_W-1:0] w_index_next;
  logic                 w_upd_cr;
  logic                 w_dead_cr;

  // ------------------------------------------------------------
  // per-parcel decode
  // ------------------------------------------------------------
  for (genvar i = 0; i < FETCH_SLOTS; i++) begin : g_slot
    logic [15:0] w_rvc;
    logic        w_is_rvc_jal;
    logic        w_is_rvc_jalr;

    assign w_rvc         = i_s2_data[i*16 +: 16];
    // low byte enable of the parcel
    assign w_slot_vld[i] = i_s2_be[2*i];
    // c.jal links x1 on rv32
    assign w_is_rvc_jal  = (w_rvc[1:0] == 2'b01) & (w_rvc[15:13] == 3'b001);
    // c.jalr, rs1 nonzero and rs2 zero
    assign w_is_rvc_jalr = (w_rvc[1:0] == 2'b10) & (w_rvc[15:12] == 4'b1001) &
                           (w_rvc[11:7] != 5'd0) & (w_rvc[6:2] == 5'd0);
    assign w_rvc_call[i] = w_is_rvc_jal | w_is_rvc_jalr;

    if (i < FETCH_SLOTS - 1) begin : g_std
      logic [31:0] w_std;
      assign w_std = i_s2_data[i*16 +: 32];
      // jal or jalr with rd = x1
      assign w_std_call[i] = (w_std[11:7] == 5'd1) &
                             ((w_std[6:0] == 7'b1101111) |
                              ((w_std[6:0] == 7'b1100111) & (w_std[14:12] == 3'b000)));
      // jalr x0, x1, 0
      assign w_std_ret[i]  = w_std == 32'h0000_8067;
    end else begin : g_last
      // upper half is in the next block, cannot decide here
      assign w_std_call[i] = 1'b0;
      assign w_std_ret[i]  = 1'b0;
    end

    // c.jr ra
    assign w_ret[i]       = ((w_rvc == 16'h8082) | w_std_ret[i]) & w_slot_vld[i];
    assign w_call_size[i] = w_std_call[i] ? STD_CALL : RVC_CALL;
  end

  // a standard call covers its following parcel too
  assign w_call = (w_rvc_call | w_std_call | (w_std_call << 1)) & w_slot_vld;
  assign w_cand = ((search_btb_if.s2_hit & search_bim_if.s2_taken) | w_call | w_ret) &
                  w_slot_vld & {FETCH_SLOTS{i_s2_valid}};

  // ------------------------------------------------------------
  // first predicted transfer from the lowest parcel
  // ------------------------------------------------------------
  always_comb begin
    w_sel     = '0;
    w_sel_hit = 1'b0;
    for (int i = FETCH_SLOTS - 1; i >= 0; i--) begin
      if (w_cand[i]) begin
        w_sel     = SLOT_W'(i);
        w_sel_hit = 1'b1;
      end
    end
  end

  assign w_win_call = w_sel_hit & w_call[w_sel];
  assign w_win_ret  = w_sel_hit & w_ret[w_sel] & ~w_call[w_sel];

  // block base + parcel offset + call length
  assign w_ret_addr = {i_s2_vaddr[VADDR_W-1:SLOT_W+1], {(SLOT_W+1){1'b0}}} +
                      VADDR_W'({w_sel, 1'b0}) +
                      ((w_call_size[w_sel] == STD_CALL) ? VADDR_W'(4) : VADDR_W'(2));

  // ------------------------------------------------------------
  // ras pointer and recovery
  // ------------------------------------------------------------
  assign w_upd_cr  = i_upd.valid & (i_upd.is_call | i_upd.is_ret);
  assign w_dead_cr = w_upd_cr & i_upd.dead;

  // only the first dead update restores the pointer
  assign w_cmt_index = (w_dead_cr & ~r_recover) ? i_upd.ras_index : r_ras_index;

  always_comb begin
    w_index_next = w_cmt_index;
    if (w_win_ret) begin
      w_index_next = w_cmt_index - 1'b1;
    end else if (w_win_call) begin
      w_index_next = w_cmt_index + 1'b1;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_recover   <= 1'b0;
      r_ras_index <= '0;
    end else begin
      r_ras_index <= w_index_next;
      // a good call or return ends recovery
      if (w_upd_cr) begin
        r_recover <= i_upd.dead;
      end
    end
  end

  assign ras_search_if.push_valid   = w_win_call;
  assign ras_search_if.push_index   = w_cmt_index;
  assign ras_search_if.push_addr    = w_ret_addr;
  assign ras_search_if.pop_index    = w_cmt_index;
  assign ras_search_if.commit_valid = i_upd.valid & i_upd.is_call;

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign o_s2_taken     = w_sel_hit;
  assign o_s2_is_call   = w_win_call;
  assign o_s2_is_ret    = w_win_ret;
  assign o_s2_ras_index = i_s2_valid ? w_cmt_index : '0;

  always_comb begin
    o_s2_target = '0;
    if (w_win_ret) begin
      o_s2_target = ras_search_if.pop_addr;
    end else if (w_sel_hit) begin
      o_s2_target = search_btb_if.s2_target[w_sel];
    end
  end

endmodule

/* pred_ras.sv */
// return address stack storage
// push above the given pointer, combinational pop read

`timescale 1ns/1ns

module pred_ras (
  input  logic           i_clk,
  input  logic           i_reset_n,
  ras_search_if.provider ras_search_if
);
  import pred_pkg::*;

  // return addresses, no reset
  logic [VADDR_W-1:0] r_addr [RAS_ENTRIES];

  // pushes still waiting for their call to resolve
  logic [RAS_IDX_W:0]   r_pend;
  logic                 w_full;
  logic                 w_push;
  logic [RAS_IDX_W-1:0] w_wr_index;

  assign w_full = r_pend == (RAS_IDX_W+1)'(RAS_ENTRIES);
  // when every slot is unresolved keep the oldest addresses,
  // a resolving call in the same cycle frees one
  assign w_push = ras_search_if.push_valid & (~w_full | ras_search_if.commit_valid);

  // index wraps at the stack depth
  assign w_wr_index = ras_search_if.push_index + 1'b1;

  always_ff @(posedge i_clk) begin
    if (w_push) begin
      r_addr[w_wr_index] <= ras_search_if.push_addr;
    end
  end

  // ------------------------------------------------------------
  // in-flight push count
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pend <= '0;
    end else begin
      case ({w_push, ras_search_if.commit_valid})
        2'b10: begin
          r_pend <= r_pend + 1'b1;
        end
        2'b01: begin
          // more resolutions than pushes, stay at zero
          if (r_pend != '0) begin
            r_pend <= r_pend - 1'b1;
          end
        end
        default: begin
          r_pend <= r_pend;
        end
      endcase
    end
  end

  assign ras_search_if.pop_addr = r_addr[ras_search_if.pop_index];

endmodule

/* pred_bim.sv */
// bimodal direction table, two-bit counter per parcel slot
// indexed like the btb, two-stage lookup

`timescale 1ns/1ns

module pred_bim (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_s0_valid,
  input  logic [pred_pkg::VADDR_W-1:0] i_s0_vaddr,
  input  pred_pkg::br_upd_t           i_upd,
  bim_search_if.provider              search_bim_if
);
  import pred_pkg::*;

  bim_cnt_t r_cnt [BTB_ENTRIES][FETCH_SLOTS];

  logic                   r_s1_valid;
  logic [BTB_IDX_W-1:0]   r_s1_idx;
  logic [FETCH_SLOTS-1:0] w_s1_taken;
  logic                   r_s2_valid;
  logic [FETCH_SLOTS-1:0] r_s2_taken;

  logic [BTB_IDX_W-1:0] w_upd_idx;
  logic [SLOT_W-1:0]    w_upd_slot;

  // one step toward the outcome, saturating at both ends
  function automatic bim_cnt_t bim_step(input bim_cnt_t cnt, input logic taken);
    bim_cnt_t nxt;
    nxt = cnt;
    if (taken && cnt != STRONG_T) begin
      nxt = bim_cnt_t'(cnt + 2'd1);
    end else if (!taken && cnt != STRONG_NT) begin
      nxt = bim_cnt_t'(cnt - 2'd1);
    end
    return nxt;
  endfunction

  assign w_upd_idx  = i_upd.pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign w_upd_slot = i_upd.pc[1 +: SLOT_W];

  // counters start weakly not-taken
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < BTB_ENTRIES; e++) begin
        for (int s = 0; s < FETCH_SLOTS; s++) begin
          r_cnt[e][s] <= WEAK_NT;
        end
      end
    end else if (i_upd.valid) begin
      r_cnt[w_upd_idx][w_upd_slot] <= bim_step(r_cnt[w_upd_idx][w_upd_slot], i_upd.taken);
    end
  end

  // ------------------------------------------------------------
  // lookup pipe
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_taken <= '0;
    end else begin
      r_s1_valid <= i_s0_valid;
      r_s2_valid <= r_s1_valid;
      r_s2_taken <= w_s1_taken;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_idx <= i_s0_vaddr[BTB_IDX_LSB +: BTB_IDX_W];
  end

  // taken in either upper state
  always_comb begin
    for (int s = 0; s < FETCH_SLOTS; s++) begin
      w_s1_taken[s] = r_cnt[r_s1_idx][s] inside {WEAK_T, STRONG_T};
    end
  end

  assign search_bim_if.s2_taken = r_s2_taken & {FETCH_SLOTS{r_s2_valid}};

endmodule

/* pred_btb.sv */
// direct-mapped branch target buffer, one entry per parcel slot
// two-stage lookup, trained by taken non-return updates

`timescale 1ns/1ns

module pred_btb (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_s0_valid,
  input  logic [pred_pkg::VADDR_W-1:0] i_s0_vaddr,
  input  pred_pkg::br_upd_t           i_upd,
  btb_search_if.provider              search_btb_if
);
  import pred_pkg::*;

  // entry storage
  logic [FETCH_SLOTS-1:0] r_valid  [BTB_ENTRIES];
  logic [BTB_TAG_W-1:0]   r_tag    [BTB_ENTRIES][FETCH_SLOTS];
  logic [VADDR_W-1:0]     r_target [BTB_ENTRIES][FETCH_SLOTS];

  // s1 lookup state
  logic                 r_s1_valid;
  logic [BTB_IDX_W-1:0] r_s1_idx;
  logic [BTB_TAG_W-1:0] r_s1_tag;
  logic [FETCH_SLOTS-1:0] w_s1_hit;

  // s2 result
  logic                                r_s2_valid;
  logic [FETCH_SLOTS-1:0]              r_s2_hit;
  logic [FETCH_SLOTS-1:0][VADDR_W-1:0] r_s2_target;

  // update decode
  logic                 w_upd_we;
  logic [BTB_IDX_W-1:0] w_upd_idx;
  logic [SLOT_W-1:0]    w_upd_slot;
  logic [BTB_TAG_W-1:0] w_upd_tag;

  // returns go through the ras, not the btb
  assign w_upd_we   = i_upd.valid & i_upd.taken & ~i_upd.is_ret;
  assign w_upd_idx  = i_upd.pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign w_upd_slot = i_upd.pc[1 +: SLOT_W];
  assign w_upd_tag  = i_upd.pc[BTB_TAG_LSB +: BTB_TAG_W];

  // ------------------------------------------------------------
  // storage write
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int e = 0; e < BTB_ENTRIES; e++) begin
        r_valid[e] <= '0;
      end
    end else if (w_upd_we) begin
      r_valid[w_upd_idx][w_upd_slot] <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_upd_we) begin
      r_tag[w_upd_idx][w_upd_slot]    <= w_upd_tag;
      r_target[w_upd_idx][w_upd_slot] <= i_upd.target;
    end
  end

  // ------------------------------------------------------------
  // s0 -> s1 -> s2 lookup
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_s1_valid <= 1'b0;
      r_s2_valid <= 1'b0;
      r_s2_hit   <= '0;
    end else begin
      r_s1_valid <= i_s0_valid;
      r_s2_valid <= r_s1_valid;
      r_s2_hit   <= w_s1_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_s1_idx <= i_s0_vaddr[BTB_IDX_LSB +: BTB_IDX_W];
    r_s1_tag <= i_s0_vaddr[BTB_TAG_LSB +: BTB_TAG_W];
    for (int s = 0; s < FETCH_SLOTS; s++) begin
      r_s2_target[s] <= r_target[r_s1_idx][s];
    end
  end

  // s1 tag compare per slot
  always_comb begin
    for (int s = 0; s < FETCH_SLOTS; s++) begin
      w_s1_hit[s] = r_valid[r_s1_idx][s] & (r_tag[r_s1_idx][s] == r_s1_tag);
    end
  end

  assign search_btb_if.s2_hit    = r_s2_hit & {FETCH_SLOTS{r_s2_valid}};
  assign search_btb_if.s2_target = r_s2_target;

endmodule

/* pred_ifs.sv */
// search interfaces between the predictor blocks
// btb_search_if, bim_search_if, ras_search_if

`timescale 1ns/1ns

// ------------------------------------------------------------
// btb results, one hit and one target per parcel
// ------------------------------------------------------------
interface btb_search_if;
  import pred_pkg::*;

  logic [FETCH_SLOTS-1:0]              s2_hit;
  logic [FETCH_SLOTS-1:0][VADDR_W-1:0] s2_target;

  modport provider (
    output s2_hit,
    output s2_target
  );

  modport lookup (
    input s2_hit,
    input s2_target
  );
endinterface

// ------------------------------------------------------------
// bimodal direction per parcel
// ------------------------------------------------------------
interface bim_search_if;
  import pred_pkg::*;

  logic [FETCH_SLOTS-1:0] s2_taken;

  modport provider (
    output s2_taken
  );

  modport lookup (
    input s2_taken
  );
endinterface

// ------------------------------------------------------------
// ras storage access, pointer lives on the lookup side
// ------------------------------------------------------------
interface ras_search_if;
  import pred_pkg::*;

  logic                 push_valid;
  logic [RAS_IDX_W-1:0] push_index;
  logic [VADDR_W-1:0]   push_addr;
  logic [RAS_IDX_W-1:0] pop_index;
  logic [VADDR_W-1:0]   pop_addr;
  // a call resolved in the back end
  logic                 commit_valid;

  modport lookup (
    output push_valid,
    output push_index,
    output push_addr,
    output pop_index,
    output commit_valid,
    input  pop_addr
  );

  modport provider (
    input  push_valid,
    input  push_index,
    input  push_addr,
    input  pop_index,
    input  commit_valid,
    output pop_addr
  );
endinterface

/* pred_pkg.sv */
// shared sizes, enums and the back-end update struct
// for the fetch-stage branch predictor (rv32c)

package pred_pkg;

  // ------------------------------------------------------------
  // sizes
  // ------------------------------------------------------------
  localparam int VADDR_W     = 32;
  // four 16-bit parcels per 64-bit fetch block
  localparam int FETCH_SLOTS = 4;
  localparam int SLOT_W      = 2;

  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = 8;
  // block index sits just above the byte offset in the block
  localparam int BTB_IDX_LSB = SLOT_W + 1;
  localparam int BTB_TAG_LSB = BTB_IDX_LSB + BTB_IDX_W;

  // ras pointer wraps around
  localparam int RAS_ENTRIES = 8;
  localparam int RAS_IDX_W   = 3;

  // ------------------------------------------------------------
  // enums
  // ------------------------------------------------------------
  // call length, gives +2 or +4 for the return address
  typedef enum logic {
    RVC_CALL = 1'b0,
    STD_CALL = 1'b1
  } call_size_t;

  // two-bit saturating counter states
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } bim_cnt_t;

  // one branch resolution from the back end
  typedef struct packed {
    logic                 valid;
    logic [VADDR_W-1:0]   pc;
    logic [VADDR_W-1:0]   target;
    logic                 taken;
    logic                 is_call;
    logic                 is_ret;
    // prediction was wrong
    logic                 dead;
    logic [RAS_IDX_W-1:0] ras_index;
  } br_upd_t;

endpackage
